// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_icache_coherence
FLAGS     ?= --binary --timing

SRCS := $(shell grep -v '^+' sim.f)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) sim.f
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f sim.f

# Output goes to the terminal and is searched for the pass line
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// File: sim.f
src/coherence_pkg.sv
src/bus_snoop_decoder.sv
src/line_state_table.sv
src/req_bus_issuer.sv
src/resp_bus_issuer.sv
src/icache_coherence.sv
verification/tb_icache_coherence.sv

// File: src/bus_snoop_decoder.sv
`timescale 1ns/10ps

module bus_snoop_decoder #(
  parameter int cache_id = 1
) (
  input  logic                                   req_valid,
  input  logic [coherence_pkg::AGENT_BITS-1:0]   req_source,
  input  coherence_pkg::bus_cmd_t                req_cmd,
  input  logic [coherence_pkg::ADDR_BITS-1:0]    req_addr,
  input  logic                                   resp_valid,
  input  logic [coherence_pkg::AGENT_BITS-1:0]   resp_source,
  input  logic [coherence_pkg::WAY_BITS-1:0]     resp_way,
  input  logic [coherence_pkg::AGENT_BITS-1:0]   resp_dest,
  input  coherence_pkg::resp_kind_t              resp_kind,
  input  logic [coherence_pkg::ADDR_BITS-1:0]    resp_addr,
  input  logic [coherence_pkg::ADDR_BITS-1:0]    dfp_addr,
  input  logic                                   cache_read_request,
  output coherence_pkg::bus_event_t              bus_event,
  output logic [coherence_pkg::SET_BITS-1:0]     event_index,
  output logic                                   cpu_load,
  output logic [coherence_pkg::SET_BITS-1:0]     cpu_index,
  output logic                                   own_req_seen,
  output logic                                   own_resp_seen,
  output logic [coherence_pkg::WAY_BITS-1:0]     resp_own_way
);

  localparam logic [coherence_pkg::AGENT_BITS-1:0] SELF =
    coherence_pkg::AGENT_BITS'(cache_id);

  assign own_req_seen  = req_valid && (req_source == SELF);
  assign own_resp_seen = resp_valid && (resp_source == SELF);
  assign resp_own_way  = resp_way;

  // CPU only gets a turn when both buses are quiet
  assign cpu_load  = cache_read_request && !req_valid && !resp_valid;
  assign cpu_index = dfp_addr[coherence_pkg::OFFSET_BITS +: coherence_pkg::SET_BITS];

  always_comb begin
    bus_event   = coherence_pkg::EV_NONE;
    event_index = req_addr[coherence_pkg::OFFSET_BITS +: coherence_pkg::SET_BITS];
    if (req_valid) begin
      if (req_source == SELF) begin
        if (req_cmd == coherence_pkg::CMD_GETS) begin
          bus_event = coherence_pkg::EV_OWN_GETS;
        end else if (req_cmd == coherence_pkg::CMD_PUTM) begin
          bus_event = coherence_pkg::EV_OWN_PUTM;
        end
      end else if (req_cmd == coherence_pkg::CMD_GETS) begin
        bus_event = coherence_pkg::EV_OTHER_GETS;
      end else if (req_cmd == coherence_pkg::CMD_GETM) begin
        bus_event = coherence_pkg::EV_OTHER_GETM;
      end
    end else if (resp_valid) begin
      event_index = resp_addr[coherence_pkg::OFFSET_BITS +: coherence_pkg::SET_BITS];
      if (resp_source == SELF) begin
        bus_event = coherence_pkg::EV_OWN_RESP;
      end else if (resp_dest == SELF) begin
        // Fill for our outstanding GetS
        if (resp_kind == coherence_pkg::RESP_DATA) begin
          bus_event = coherence_pkg::EV_FILL_SHARED;
        end else if (resp_kind == coherence_pkg::RESP_EXCL) begin
          bus_event = coherence_pkg::EV_FILL_EXCL;
        end
      end
    end
  end

endmodule

// File: src/coherence_pkg.sv
package coherence_pkg;

  // Bus and cache geometry
  localparam int ADDR_BITS   = 32;
  localparam int LINE_BITS   = 256;
  localparam int OFFSET_BITS = 5;
  localparam int WAYS        = 4;
  localparam int SETS        = 16;
  localparam int SET_BITS    = 4;
  localparam int WAY_BITS    = 2;

  // Agent numbering on both buses
  localparam int AGENT_BITS = 3;
  localparam int MEMORY_ID  = 4;

  // Per-line coherence state, MESI without M
  typedef enum logic [3:0] {
    LS_I,
    LS_ISAD,
    LS_ISD,
    LS_S,
    LS_E,
    LS_SRD,
    LS_IRD,
    LS_EIA,
    LS_IIARD,
    LS_IIA
  } line_state_t;

  typedef enum logic [1:0] {
    CMD_NONE,
    CMD_GETS,
    CMD_GETM,
    CMD_PUTM
  } bus_cmd_t;

  typedef enum logic [1:0] {
    RESP_DATA,
    RESP_EXCL,
    RESP_NODATA,
    RESP_NODATAE
  } resp_kind_t;

  // One event per cycle after bus and CPU priority
  typedef enum logic [2:0] {
    EV_NONE,
    EV_OWN_GETS,
    EV_OWN_PUTM,
    EV_OTHER_GETS,
    EV_OTHER_GETM,
    EV_FILL_SHARED,
    EV_FILL_EXCL,
    EV_OWN_RESP
  } bus_event_t;

endpackage

// File: src/icache_coherence.sv
`timescale 1ns/10ps

module icache_coherence #(
  parameter int cache_id = 1
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  dfp_read,
  input  logic                                  cache_read_request,
  input  logic [coherence_pkg::ADDR_BITS-1:0]   dfp_addr,
  output logic [coherence_pkg::LINE_BITS-1:0]   dfp_rdata,
  output logic                                  dfp_resp,
  input  logic [coherence_pkg::WAYS-1:0]        cache_hit_vector,
  input  logic [coherence_pkg::WAYS-1:0]        bus_hit_vector,
  input  logic [coherence_pkg::WAYS-1:0]        evict_candidate,
  input  logic [coherence_pkg::LINE_BITS-1:0]   bus_rdata,
  input  logic                                  req_valid,
  input  logic [coherence_pkg::AGENT_BITS-1:0]  req_source,
  input  logic [coherence_pkg::ADDR_BITS-1:0]   req_addr,
  input  coherence_pkg::bus_cmd_t               req_cmd,
  output logic                                  req_bus_req,
  output logic [coherence_pkg::ADDR_BITS-1:0]   req_tx_addr,
  output coherence_pkg::bus_cmd_t               req_tx_cmd,
  output logic                                  req_bus_busy,
  input  logic                                  resp_valid,
  input  logic [coherence_pkg::AGENT_BITS-1:0]  resp_source,
  input  logic [coherence_pkg::WAY_BITS-1:0]    resp_way,
  input  logic [coherence_pkg::AGENT_BITS-1:0]  resp_dest,
  input  coherence_pkg::resp_kind_t             resp_kind,
  input  logic [coherence_pkg::ADDR_BITS-1:0]   resp_addr,
  input  logic [coherence_pkg::LINE_BITS-1:0]   resp_data,
  output logic                                  resp_bus_req,
  output logic [coherence_pkg::WAY_BITS-1:0]    resp_tx_way,
  output logic [coherence_pkg::AGENT_BITS-1:0]  resp_tx_dest,
  output logic                                  resp_tx_memory,
  output logic [coherence_pkg::ADDR_BITS-1:0]   resp_tx_addr,
  output logic [coherence_pkg::LINE_BITS-1:0]   resp_tx_data,
  output coherence_pkg::resp_kind_t             resp_tx_kind
);

  coherence_pkg::bus_event_t            bus_event;
  logic [coherence_pkg::SET_BITS-1:0]   event_index;
  logic [coherence_pkg::SET_BITS-1:0]   cpu_index;
  logic [coherence_pkg::WAY_BITS-1:0]   resp_own_way;
  logic                                 cpu_load;
  logic                                 own_req_seen;
  logic                                 own_resp_seen;
  logic                                 issue_gets;
  logic                                 issue_putm;
  logic [coherence_pkg::ADDR_BITS-1:0]  issue_addr;
  logic                                 send_data;
  logic [coherence_pkg::WAY_BITS-1:0]   send_way;
  logic                                 send_memory;
  logic                                 send_putm_ack;
  coherence_pkg::resp_kind_t            ack_kind;
  logic                                 fill_done;
  logic                                 load_hit;
  logic                                 busy_set;
  logic                                 busy_clear;

  bus_snoop_decoder #(.cache_id(cache_id)) u_decoder (
    .req_valid, .req_source, .req_cmd, .req_addr,
    .resp_valid, .resp_source, .resp_way, .resp_dest, .resp_kind, .resp_addr,
    .dfp_addr, .cache_read_request,
    .bus_event, .event_index, .cpu_load, .cpu_index,
    .own_req_seen, .own_resp_seen, .resp_own_way
  );

  line_state_table u_table (
    .clk, .rst, .bus_event, .event_index, .resp_own_way,
    .cpu_load, .cpu_index, .dfp_read, .dfp_addr,
    .cache_hit_vector, .bus_hit_vector, .evict_candidate,
    .issue_gets, .issue_putm, .issue_addr,
    .send_data, .send_way, .send_memory, .send_putm_ack, .ack_kind,
    .fill_done, .load_hit, .busy_set, .busy_clear
  );

  req_bus_issuer u_req_issuer (
    .clk, .rst, .issue_gets, .issue_putm, .issue_addr,
    .own_req_seen, .busy_set, .busy_clear,
    .req_bus_req, .req_tx_addr, .req_tx_cmd, .req_bus_busy
  );

  resp_bus_issuer #(.cache_id(cache_id)) u_resp_issuer (
    .clk, .rst, .send_data, .send_way, .send_memory, .send_putm_ack, .ack_kind,
    .req_source, .req_addr, .bus_rdata, .own_resp_seen,
    .fill_done, .load_hit, .resp_data,
    .resp_bus_req, .resp_tx_way, .resp_tx_dest, .resp_tx_memory,
    .resp_tx_addr, .resp_tx_data, .resp_tx_kind, .dfp_rdata, .dfp_resp
  );

endmodule

// File: src/line_state_table.sv
`timescale 1ns/10ps

module line_state_table (
  input  logic                                 clk,
  input  logic                                 rst,
  input  coherence_pkg::bus_event_t            bus_event,
  input  logic [coherence_pkg::SET_BITS-1:0]   event_index,
  input  logic [coherence_pkg::WAY_BITS-1:0]   resp_own_way,
  input  logic                                 cpu_load,
  input  logic [coherence_pkg::SET_BITS-1:0]   cpu_index,
  input  logic                                 dfp_read,
  input  logic [coherence_pkg::ADDR_BITS-1:0]  dfp_addr,
  input  logic [coherence_pkg::WAYS-1:0]       cache_hit_vector,
  input  logic [coherence_pkg::WAYS-1:0]       bus_hit_vector,
  input  logic [coherence_pkg::WAYS-1:0]       evict_candidate,
  output logic                                 issue_gets,
  output logic                                 issue_putm,
  output logic [coherence_pkg::ADDR_BITS-1:0]  issue_addr,
  output logic                                 send_data,
  output logic [coherence_pkg::WAY_BITS-1:0]   send_way,
  output logic                                 send_memory,
  output logic                                 send_putm_ack,
  output coherence_pkg::resp_kind_t            ack_kind,
  output logic                                 fill_done,
  output logic                                 load_hit,
  output logic                                 busy_set,
  output logic                                 busy_clear
);

  coherence_pkg::line_state_t state_q [coherence_pkg::WAYS][coherence_pkg::SETS];
  coherence_pkg::line_state_t cur [coherence_pkg::WAYS];
  coherence_pkg::line_state_t nxt [coherence_pkg::WAYS];
  logic [coherence_pkg::SET_BITS-1:0] idx;

  // The decoder keeps bus events and CPU requests apart
  assign idx        = cpu_load ? cpu_index : event_index;
  assign issue_addr = dfp_addr;

  always_comb begin
    issue_gets    = 1'b0;
    issue_putm    = 1'b0;
    send_data     = 1'b0;
    send_way      = '0;
    send_memory   = 1'b0;
    send_putm_ack = 1'b0;
    ack_kind      = coherence_pkg::RESP_NODATA;
    fill_done     = 1'b0;
    load_hit      = 1'b0;
    busy_set      = 1'b0;
    busy_clear    = 1'b0;
    for (int w = 0; w < coherence_pkg::WAYS; w++) begin
      cur[w] = state_q[w][idx];
      nxt[w] = cur[w];
      if (cpu_load) begin
        // Hit first, then miss or replacement on the victim way
        if (cache_hit_vector[w] && (cur[w] inside {coherence_pkg::LS_S, coherence_pkg::LS_E,
                                                   coherence_pkg::LS_EIA})) begin
          load_hit = 1'b1;
        end else if (dfp_read && evict_candidate[w]) begin
          if (cur[w] == coherence_pkg::LS_I) begin
            nxt[w]     = coherence_pkg::LS_ISAD;
            issue_gets = 1'b1;
          end else if (cur[w] == coherence_pkg::LS_S) begin
            nxt[w] = coherence_pkg::LS_I;
          end else if (cur[w] == coherence_pkg::LS_E) begin
            nxt[w]     = coherence_pkg::LS_EIA;
            issue_putm = 1'b1;
          end
        end
      end else begin
        unique case (bus_event)
          coherence_pkg::EV_OWN_GETS: begin
            if (cur[w] == coherence_pkg::LS_ISAD && evict_candidate[w]) begin
              nxt[w]   = coherence_pkg::LS_ISD;
              busy_set = 1'b1;
            end
          end
          coherence_pkg::EV_OWN_PUTM: begin
            if (evict_candidate[w] && (cur[w] inside {coherence_pkg::LS_EIA,
                                                      coherence_pkg::LS_IIA})) begin
              nxt[w]        = coherence_pkg::LS_I;
              send_putm_ack = 1'b1;
              send_way      = coherence_pkg::WAY_BITS'(w);
              // Data already went out during the race, so no ownership to return
              ack_kind      = (cur[w] == coherence_pkg::LS_EIA) ?
                              coherence_pkg::RESP_NODATAE : coherence_pkg::RESP_NODATA;
            end
          end
          coherence_pkg::EV_OTHER_GETS, coherence_pkg::EV_OTHER_GETM: begin
            if (bus_hit_vector[w]) begin
              if (cur[w] == coherence_pkg::LS_S &&
                  bus_event == coherence_pkg::EV_OTHER_GETM) begin
                nxt[w] = coherence_pkg::LS_I;
              end else if (cur[w] inside {coherence_pkg::LS_E, coherence_pkg::LS_EIA}) begin
                if (cur[w] == coherence_pkg::LS_EIA) begin
                  nxt[w] = coherence_pkg::LS_IIARD;
                end else if (bus_event == coherence_pkg::EV_OTHER_GETS) begin
                  nxt[w] = coherence_pkg::LS_SRD;
                end else begin
                  nxt[w] = coherence_pkg::LS_IRD;
                end
                send_data   = 1'b1;
                send_way    = coherence_pkg::WAY_BITS'(w);
                send_memory = (bus_event == coherence_pkg::EV_OTHER_GETS);
                busy_set    = 1'b1;
              end
            end
          end
          coherence_pkg::EV_FILL_SHARED, coherence_pkg::EV_FILL_EXCL: begin
            if (cur[w] == coherence_pkg::LS_ISD && evict_candidate[w]) begin
              nxt[w]     = (bus_event == coherence_pkg::EV_FILL_EXCL) ?
                           coherence_pkg::LS_E : coherence_pkg::LS_S;
              fill_done  = 1'b1;
              busy_clear = 1'b1;
            end
          end
          coherence_pkg::EV_OWN_RESP: begin
            if (resp_own_way == coherence_pkg::WAY_BITS'(w)) begin
              if (cur[w] == coherence_pkg::LS_SRD) begin
                nxt[w]     = coherence_pkg::LS_S;
                busy_clear = 1'b1;
              end else if (cur[w] == coherence_pkg::LS_IRD) begin
                nxt[w]     = coherence_pkg::LS_I;
                busy_clear = 1'b1;
              end else if (cur[w] == coherence_pkg::LS_IIARD) begin
                nxt[w]     = coherence_pkg::LS_IIA;
                busy_clear = 1'b1;
              end
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < coherence_pkg::WAYS; w++) begin
        for (int s = 0; s < coherence_pkg::SETS; s++) begin
          state_q[w][s] <= coherence_pkg::LS_I;
        end
      end
    end else begin
      for (int w = 0; w < coherence_pkg::WAYS; w++) begin
        state_q[w][idx] <= nxt[w];
      end
    end
  end

endmodule

// File: src/req_bus_issuer.sv
`timescale 1ns/10ps

module req_bus_issuer (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 issue_gets,
  input  logic                                 issue_putm,
  input  logic [coherence_pkg::ADDR_BITS-1:0]  issue_addr,
  input  logic                                 own_req_seen,
  input  logic                                 busy_set,
  input  logic                                 busy_clear,
  output logic                                 req_bus_req,
  output logic [coherence_pkg::ADDR_BITS-1:0]  req_tx_addr,
  output coherence_pkg::bus_cmd_t              req_tx_cmd,
  output logic                                 req_bus_busy
);

  // Message is held until our own copy shows up on the bus
  always_ff @(posedge clk) begin
    if (rst) begin
      req_bus_req  <= 1'b0;
      req_tx_cmd   <= coherence_pkg::CMD_NONE;
      req_bus_busy <= 1'b0;
    end else begin
      if (issue_gets || issue_putm) begin
        req_bus_req <= 1'b1;
        req_tx_cmd  <= issue_gets ? coherence_pkg::CMD_GETS : coherence_pkg::CMD_PUTM;
      end else if (own_req_seen) begin
        req_bus_req <= 1'b0;
        req_tx_cmd  <= coherence_pkg::CMD_NONE;
      end
      if (busy_set) begin
        req_bus_busy <= 1'b1;
      end else if (busy_clear) begin
        req_bus_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue_gets || issue_putm) begin
      req_tx_addr <= issue_addr;
    end
  end

endmodule

// File: src/resp_bus_issuer.sv
`timescale 1ns/10ps

module resp_bus_issuer #(
  parameter int cache_id = 1
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  send_data,
  input  logic [coherence_pkg::WAY_BITS-1:0]    send_way,
  input  logic                                  send_memory,
  input  logic                                  send_putm_ack,
  input  coherence_pkg::resp_kind_t             ack_kind,
  input  logic [coherence_pkg::AGENT_BITS-1:0]  req_source,
  input  logic [coherence_pkg::ADDR_BITS-1:0]   req_addr,
  input  logic [coherence_pkg::LINE_BITS-1:0]   bus_rdata,
  input  logic                                  own_resp_seen,
  input  logic                                  fill_done,
  input  logic                                  load_hit,
  input  logic [coherence_pkg::LINE_BITS-1:0]   resp_data,
  output logic                                  resp_bus_req,
  output logic [coherence_pkg::WAY_BITS-1:0]    resp_tx_way,
  output logic [coherence_pkg::AGENT_BITS-1:0]  resp_tx_dest,
  output logic                                  resp_tx_memory,
  output logic [coherence_pkg::ADDR_BITS-1:0]   resp_tx_addr,
  output logic [coherence_pkg::LINE_BITS-1:0]   resp_tx_data,
  output coherence_pkg::resp_kind_t             resp_tx_kind,
  output logic [coherence_pkg::LINE_BITS-1:0]   dfp_rdata,
  output logic                                  dfp_resp
);

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_bus_req <= 1'b0;
      resp_tx_kind <= coherence_pkg::RESP_NODATA;
      dfp_resp     <= 1'b0;
    end else begin
      dfp_resp <= fill_done || load_hit;
      if (send_data) begin
        resp_bus_req <= 1'b1;
        resp_tx_kind <= coherence_pkg::RESP_DATA;
      end else if (send_putm_ack) begin
        resp_bus_req <= 1'b1;
        resp_tx_kind <= ack_kind;
      end else if (own_resp_seen) begin
        resp_bus_req <= 1'b0;
        resp_tx_kind <= coherence_pkg::RESP_NODATA;
      end
    end
  end

  // Payload of the held response
  always_ff @(posedge clk) begin
    if (send_data || send_putm_ack) begin
      resp_tx_way  <= send_way;
      resp_tx_addr <= req_addr;
      resp_tx_data <= bus_rdata;
      // PutM acks always go to memory
      resp_tx_dest   <= send_data ? req_source :
                        coherence_pkg::AGENT_BITS'(coherence_pkg::MEMORY_ID);
      resp_tx_memory <= send_data ? send_memory : 1'b1;
    end else if (own_resp_seen) begin
      resp_tx_dest   <= coherence_pkg::AGENT_BITS'(cache_id);
      resp_tx_memory <= 1'b0;
    end
    if (fill_done) begin
      dfp_rdata <= resp_data;
    end
  end

endmodule

// File: verification/tb_icache_coherence.sv
`timescale 1ns/10ps

module tb_icache_coherence;

  localparam int WAIT_LIMIT = 20;
  localparam logic [31:0] LINE_ADDR = 32'h1000_0060;

  localparam coherence_pkg::bus_cmd_t NONE = coherence_pkg::CMD_NONE;
  localparam coherence_pkg::bus_cmd_t GETS = coherence_pkg::CMD_GETS;
  localparam coherence_pkg::bus_cmd_t GETM = coherence_pkg::CMD_GETM;
  localparam coherence_pkg::bus_cmd_t PUTM = coherence_pkg::CMD_PUTM;
  localparam coherence_pkg::resp_kind_t DATA = coherence_pkg::RESP_DATA;
  localparam coherence_pkg::resp_kind_t EXCL = coherence_pkg::RESP_EXCL;
  localparam coherence_pkg::resp_kind_t NODATA = coherence_pkg::RESP_NODATA;
  localparam coherence_pkg::resp_kind_t NODATAE = coherence_pkg::RESP_NODATAE;

  // A set bit in the care mask selects a payload field to check
  localparam logic [3:0] CARE_ADDR = 4'b0001;
  localparam logic [3:0] CARE_RESP = 4'b0010;
  localparam logic [3:0] CARE_FILL = 4'b0100;
  localparam logic [3:0] CARE_TXD  = 4'b1000;

  typedef enum logic [1:0] {OP_IDLE, OP_LOAD, OP_REQ, OP_RESP} op_t;

  typedef struct {
    op_t                       op;
    logic [2:0]                src;
    logic [2:0]                dst;
    coherence_pkg::bus_cmd_t   cmd;
    coherence_pkg::resp_kind_t kind;
    logic [1:0]                way;
    logic [3:0]                hit;
    logic [3:0]                bhit;
    logic [3:0]                evict;
    logic                      e_req;
    coherence_pkg::bus_cmd_t   e_cmd;
    logic                      e_resp;
    coherence_pkg::resp_kind_t e_kind;
    logic [2:0]                e_dest;
    logic                      e_mem;
    logic                      e_busy;
    logic                      e_dfp;
    logic [3:0]                care;
  } row_t;

  logic clk;
  logic rst;
  logic dfp_read;
  logic cache_read_request;
  logic [31:0] dfp_addr;
  logic [255:0] dfp_rdata;
  logic dfp_resp;
  logic [3:0] cache_hit_vector;
  logic [3:0] bus_hit_vector;
  logic [3:0] evict_candidate;
  logic [255:0] bus_rdata;
  logic req_valid;
  logic [2:0] req_source;
  logic [31:0] req_addr;
  coherence_pkg::bus_cmd_t req_cmd;
  logic req_bus_req;
  logic [31:0] req_tx_addr;
  coherence_pkg::bus_cmd_t req_tx_cmd;
  logic req_bus_busy;
  logic resp_valid;
  logic [2:0] resp_source;
  logic [1:0] resp_way;
  logic [2:0] resp_dest;
  coherence_pkg::resp_kind_t resp_kind;
  logic [31:0] resp_addr;
  logic [255:0] resp_data;
  logic resp_bus_req;
  logic [1:0] resp_tx_way;
  logic [2:0] resp_tx_dest;
  logic resp_tx_memory;
  logic [31:0] resp_tx_addr;
  logic [255:0] resp_tx_data;
  coherence_pkg::resp_kind_t resp_tx_kind;

  row_t rows[$];
  int row_num;
  logic [31:0] lcg_state;

  icache_coherence #(.cache_id(1)) dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [255:0] random_line();
    logic [255:0] v;
    for (int i = 0; i < 8; i++) begin
      v[i*32 +: 32] = next_random();
    end
    return v;
  endfunction

  // Way that holds the snooped or evicted line
  function automatic logic [1:0] line_way(input logic [3:0] vec);
    logic [1:0] way;
    way = '0;
    for (int w = 0; w < 4; w++) begin
      if (vec[w]) begin
        way = 2'(w);
      end
    end
    return way;
  endfunction

  task automatic fail_run();
    $display("Test failures found");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH row %0d %s: got %h, expected %h", row_num, name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_cmd(input string name, input coherence_pkg::bus_cmd_t got,
                           input coherence_pkg::bus_cmd_t exp);
    if (got !== exp) begin
      $display("MISMATCH row %0d %s: got %h, expected %h", row_num, name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_kind(input string name, input coherence_pkg::resp_kind_t got,
                            input coherence_pkg::resp_kind_t exp);
    if (got !== exp) begin
      $display("MISMATCH row %0d %s: got %h, expected %h", row_num, name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH row %0d %s: got %h, expected %h", row_num, name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_data(input string name, input logic [255:0] got,
                            input logic [255:0] exp);
    if (got !== exp) begin
      $display("MISMATCH row %0d %s: got %h, expected %h", row_num, name, got, exp);
      fail_run();
    end
  endtask

  // Own bus messages only make sense while the matching request is held
  task automatic wait_held(input logic is_resp);
    int n;
    n = 0;
    while (((is_resp ? resp_bus_req : req_bus_req) !== 1'b1) && (n < WAIT_LIMIT)) begin
      @(posedge clk);
      #1;
      n++;
    end
    if ((is_resp ? resp_bus_req : req_bus_req) !== 1'b1) begin
      $display("Timeout at row %0d: the DUT never raised its held bus request", row_num);
      fail_run();
    end
  endtask

  task automatic add_row(input op_t op, input logic [2:0] src, input logic [2:0] dst,
                         input coherence_pkg::bus_cmd_t cmd,
                         input coherence_pkg::resp_kind_t kind, input logic [1:0] way,
                         input logic [3:0] hit, input logic [3:0] bhit,
                         input logic [3:0] evict, input logic e_req,
                         input coherence_pkg::bus_cmd_t e_cmd, input logic e_resp,
                         input coherence_pkg::resp_kind_t e_kind, input logic [2:0] e_dest,
                         input logic e_mem, input logic e_busy, input logic e_dfp,
                         input logic [3:0] care);
    row_t r;
    r = '{op, src, dst, cmd, kind, way, hit, bhit, evict,
          e_req, e_cmd, e_resp, e_kind, e_dest, e_mem, e_busy, e_dfp, care};
    rows.push_back(r);
  endtask

  task automatic drive_row(input row_t r);
    dfp_read           = (r.op == OP_LOAD);
    cache_read_request = (r.op == OP_LOAD);
    cache_hit_vector   = r.hit;
    bus_hit_vector     = r.bhit;
    evict_candidate    = r.evict;
    req_valid          = (r.op == OP_REQ);
    req_source         = r.src;
    req_cmd            = r.cmd;
    resp_valid         = (r.op == OP_RESP);
    resp_source        = r.src;
    resp_dest          = r.dst;
    resp_kind          = r.kind;
    resp_way           = r.way;
    bus_rdata          = random_line();
    resp_data          = random_line();
  endtask

  task automatic check_row(input row_t r, input logic [255:0] sent_bus,
                           input logic [255:0] sent_fill);
    check_bit("req_bus_req", req_bus_req, r.e_req);
    check_cmd("req_tx_cmd", req_tx_cmd, r.e_cmd);
    check_bit("resp_bus_req", resp_bus_req, r.e_resp);
    check_kind("resp_tx_kind", resp_tx_kind, r.e_kind);
    check_bit("req_bus_busy", req_bus_busy, r.e_busy);
    check_bit("dfp_resp", dfp_resp, r.e_dfp);
    if (r.care & CARE_ADDR) begin
      check_addr("req_tx_addr", req_tx_addr, LINE_ADDR);
    end
    if (r.care & CARE_RESP) begin
      check_addr("resp_tx_dest", {29'd0, resp_tx_dest}, {29'd0, r.e_dest});
      check_addr("resp_tx_way", {30'd0, resp_tx_way}, {30'd0, line_way(r.bhit | r.evict)});
      check_bit("resp_tx_memory", resp_tx_memory, r.e_mem);
      check_addr("resp_tx_addr", resp_tx_addr, LINE_ADDR);
    end
    if (r.care & CARE_TXD) begin
      check_data("resp_tx_data", resp_tx_data, sent_bus);
    end
    if (r.care & CARE_FILL) begin
      check_data("dfp_rdata", dfp_rdata, sent_fill);
    end
  endtask

  initial begin
    logic [255:0] sent_bus;
    logic [255:0] sent_fill;
    lcg_state = 32'd44;
    row_num = 0;
    rst = 1'b1;
    dfp_addr = LINE_ADDR;
    req_addr = LINE_ADDR;
    resp_addr = LINE_ADDR;
    drive_row('{OP_IDLE, 0, 0, NONE, DATA, 0, 0, 0, 0, 0, NONE, 0, NODATA, 0, 0, 0, 0, 0});

    // Load miss on way 0, shared fill, then a hit
    add_row(OP_LOAD, 0, 0, NONE, DATA, 0, 4'b0000, 4'b0000, 4'b0001,
            1, GETS, 0, NODATA, 0, 0, 0, 0, CARE_ADDR);
    add_row(OP_IDLE, 0, 0, NONE, DATA, 0, 4'b0000, 4'b0000, 4'b0000,
            1, GETS, 0, NODATA, 0, 0, 0, 0, CARE_ADDR);
    add_row(OP_REQ, 1, 0, GETS, DATA, 0, 4'b0000, 4'b0000, 4'b0001,
            0, NONE, 0, NODATA, 0, 0, 1, 0, 0);
    add_row(OP_RESP, 4, 1, NONE, DATA, 0, 4'b0000, 4'b0000, 4'b0001,
            0, NONE, 0, NODATA, 0, 0, 0, 1, CARE_FILL);
    add_row(OP_IDLE, 0, 0, NONE, DATA, 0, 4'b0000, 4'b0000, 4'b0000,
            0, NONE, 0, NODATA, 0, 0, 0, 0, 0);
    add_row(OP_LOAD, 0, 0, NONE, DATA, 0, 4'b0001, 4'b0000, 4'b0000,
            0, NONE, 0, NODATA, 0, 0, 0, 1, 0);
    add_row(OP_IDLE, 0, 0, NONE, DATA, 0, 4'b0000, 4'b0000, 4'b0000,
            0, NONE, 0, NODATA, 0, 0, 0, 0, 0);
    // Exclusive fill on way 1, then snooped GetS and GetM
    add_row(OP_LOAD, 0, 0, NONE, DATA, 0, 4'b0000, 4'b0000, 4'b0010,
            1, GETS, 0, NODATA, 0, 0, 0, 0, CARE_ADDR);
    add_row(OP_REQ, 1, 0, GETS, DATA, 0, 4'b0000, 4'b0000, 4'b0010,
            0, NONE, 0, NODATA, 0, 0, 1, 0, 0);
    add_row(OP_RESP, 4, 1, NONE, EXCL, 0, 4'b0000, 4'b0000, 4'b0010,
            0, NONE, 0, NODATA, 0, 0, 0, 1, CARE_FILL);
    add_row(OP_REQ, 2, 0, GETS, DATA, 0, 4'b0000, 4'b0010, 4'b0000,
            0, NONE, 1, DATA, 2, 1, 1, 0, CARE_RESP | CARE_TXD);
    add_row(OP_RESP, 1, 0, NONE, DATA, 1, 4'b0000, 4'b0000, 4'b0000,
            0, NONE, 0, NODATA, 0, 0, 0, 0, 0);
    add_row(OP_REQ, 2, 0, GETM, DATA, 0, 4'b0000, 4'b0010, 4'b0000,
            0, NONE, 0, NODATA, 0, 0, 0, 0, 0);
    add_row(OP_LOAD, 0, 0, NONE, DATA, 0, 4'b0010, 4'b0000, 4'b0010,
            1, GETS, 0, NODATA, 0, 0, 0, 0, CARE_ADDR);
    add_row(OP_REQ, 1, 0, GETS, DATA, 0, 4'b0000, 4'b0000, 4'b0010,
            0, NONE, 0, NODATA, 0, 0, 1, 0, 0);
    add_row(OP_RESP, 4, 1, NONE, EXCL, 0, 4'b0000, 4'b0000, 4'b0010,
            0, NONE, 0, NODATA, 0, 0, 0, 1, CARE_FILL);
    // Replacement of the E line through PutM
    add_row(OP_LOAD, 0, 0, NONE, DATA, 0, 4'b0000, 4'b0000, 4'b0010,
            1, PUTM, 0, NODATA, 0, 0, 0, 0, CARE_ADDR);
    add_row(OP_REQ, 1, 0, PUTM, DATA, 0, 4'b0000, 4'b0000, 4'b0010,
            0, NONE, 1, NODATAE, 4, 1, 0, 0, CARE_RESP);
    add_row(OP_RESP, 1, 0, NONE, DATA, 1, 4'b0000, 4'b0000, 4'b0000,
            0, NONE, 0, NODATA, 0, 0, 0, 0, 0);
    add_row(OP_LOAD, 0, 0, NONE, DATA, 0, 4'b0010, 4'b0000, 4'b0010,
            1, GETS, 0, NODATA, 0, 0, 0, 0, CARE_ADDR);
    add_row(OP_REQ, 1, 0, GETS, DATA, 0, 4'b0000, 4'b0000, 4'b0010,
            0, NONE, 0, NODATA, 0, 0, 1, 0, 0);
    add_row(OP_RESP, 4, 1, NONE, EXCL, 0, 4'b0000, 4'b0000, 4'b0010,
            0, NONE, 0, NODATA, 0, 0, 0, 1, CARE_FILL);
    // Race between own PutM and another cache's GetM
    add_row(OP_LOAD, 0, 0, NONE, DATA, 0, 4'b0000, 4'b0000, 4'b0010,
            1, PUTM, 0, NODATA, 0, 0, 0, 0, CARE_ADDR);
    add_row(OP_REQ, 3, 0, GETM, DATA, 0, 4'b0000, 4'b0010, 4'b0000,
            1, PUTM, 1, DATA, 3, 0, 1, 0, CARE_ADDR | CARE_RESP | CARE_TXD);
    add_row(OP_RESP, 1, 0, NONE, DATA, 1, 4'b0000, 4'b0000, 4'b0000,
            1, PUTM, 0, NODATA, 0, 0, 0, 0, CARE_ADDR);
    add_row(OP_REQ, 1, 0, PUTM, DATA, 0, 4'b0000, 4'b0000, 4'b0010,
            0, NONE, 1, NODATA, 4, 1, 0, 0, CARE_RESP);
    add_row(OP_RESP, 1, 0, NONE, DATA, 1, 4'b0000, 4'b0000, 4'b0000,
            0, NONE, 0, NODATA, 0, 0, 0, 0, 0);

    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    check_bit("req_bus_req", req_bus_req, 1'b0);
    check_bit("resp_bus_req", resp_bus_req, 1'b0);
    check_bit("req_bus_busy", req_bus_busy, 1'b0);
    check_bit("dfp_resp", dfp_resp, 1'b0);

    foreach (rows[i]) begin
      row_num = i + 1;
      if (rows[i].src == 3'd1 && rows[i].op == OP_REQ) begin
        wait_held(1'b0);
      end else if (rows[i].src == 3'd1 && rows[i].op == OP_RESP) begin
        wait_held(1'b1);
      end
      drive_row(rows[i]);
      sent_bus  = bus_rdata;
      sent_fill = resp_data;
      @(posedge clk);
      #1;
      check_row(rows[i], sent_bus, sent_fill);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule
